//--- Makefile
VERILATOR  ?= verilator
TOP        := decodeStageTb
FILELIST   := flist.f
BUILD_DIR  := build
LOG        := $(BUILD_DIR)/sim.log
FLAGS      := --binary --timing --assert -j 0 --top-module $(TOP) -Mdir $(BUILD_DIR)
LINT_FLAGS := --lint-only -Wall --timing --top-module $(TOP)
PASS_TEXT  := Finished with no errors

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) -f $(FILELIST)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_TEXT)" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)

//--- flist.f
+incdir+include
logic/decodePkg.sv
logic/instructionDecoder.sv
logic/immediateGenerator.sv
logic/stageRegister.sv
logic/decodeStage.sv
tb/clockReset.sv
tb/decodeStageTb.sv

//--- include/decode_config.svh
`ifndef DECODE_CONFIG_SVH
`define DECODE_CONFIG_SVH

// Datapath and address width of the core
`define XLEN 32

`define REG_ADDR_WIDTH 5 // x0 to x31

// funct7 codes shared by the register and immediate ALU formats
`define FUNCT7_BASE 7'b0000000
`define FUNCT7_ALT  7'b0100000 // SUB and SRA/SRAI

`endif

//--- logic/decodePkg.sv
`include "decode_config.svh"

package decodePkg;

    typedef enum logic [6:0] {
        OPCODE_ALU_REG  = 7'b0110011,
        OPCODE_ALU_IMM  = 7'b0010011,
        OPCODE_LOAD     = 7'b0000011,
        OPCODE_STORE    = 7'b0100011,
        OPCODE_BRANCH   = 7'b1100011,
        OPCODE_LUI      = 7'b0110111,
        OPCODE_AUIPC    = 7'b0010111,
        OPCODE_JAL      = 7'b1101111,
        OPCODE_JALR     = 7'b1100111,
        OPCODE_MISC_MEM = 7'b0001111, // FENCE
        OPCODE_SYSTEM   = 7'b1110011
    } opcode_t;

    typedef enum logic [3:0] {
        ALU_ADD, // Zero so a bubble decodes as ADD
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_SLT,
        ALU_SLTU
    } aluOperation_t;

    typedef enum logic [1:0] {
        ALU_RS1_RS2,
        ALU_RS1_IMM,
        ALU_PC_IMM,
        ALU_ZERO_IMM // LUI
    } aluSource_t;

    typedef enum logic [1:0] {
        WB_NONE,
        WB_ALU,
        WB_MEM,
        WB_PC4 // Link address for jumps
    } writebackType_t;

    typedef enum logic [2:0] {
        BR_NONE,
        BR_EQ,
        BR_NE,
        BR_LT,
        BR_GE,
        BR_LTU,
        BR_GEU
    } branchType_t;

    typedef enum logic [1:0] {
        JUMP_NONE,
        JUMP_JAL,
        JUMP_JALR
    } jumpType_t;

    typedef enum logic [1:0] {
        MEM_BYTE = 2'b00,
        MEM_HALF = 2'b01,
        MEM_WORD = 2'b11
    } memoryWidth_t;

    typedef enum logic [2:0] {
        IMM_NONE,
        IMM_I,
        IMM_S,
        IMM_B,
        IMM_U,
        IMM_J
    } immediateFormat_t;

    typedef struct packed {
        logic [`XLEN-1:0] instruction;
        logic [`XLEN-1:0] programCounter;
        logic [`XLEN-1:0] programCounterPlus4;
        logic             valid;
    } fetchDecodePayload_t;

    typedef struct packed {
        aluOperation_t              aluOperation;
        aluSource_t                 aluSource;
        writebackType_t             writebackType;
        logic                       memoryReadEnable;
        logic                       memoryWriteEnable;
        memoryWidth_t               memoryWidth;
        logic                       memorySigned;
        branchType_t                branchType;
        jumpType_t                  jumpType;
        logic [`XLEN-1:0]           immediate;
        logic [`REG_ADDR_WIDTH-1:0] destinationRegister;
        logic [`REG_ADDR_WIDTH-1:0] readAddress1;
        logic [`REG_ADDR_WIDTH-1:0] readAddress2;
        logic [`XLEN-1:0]           registerData1;
        logic [`XLEN-1:0]           registerData2;
        logic [`XLEN-1:0]           programCounter;
        logic [`XLEN-1:0]           programCounterPlus4;
        logic                       valid;
        logic                       illegal;
    } decodeExecutePayload_t;

    typedef struct packed {
        logic flush;
        logic stall; // Hold, execute is busy
    } pipelineControl_t;

endpackage

//--- logic/decodeStage.sv
`timescale 1ns/10ps
`include "decode_config.svh"

module decodeStage import decodePkg::*; (
    input  logic                        clock,
    input  logic                        reset,
    input  fetchDecodePayload_t         fetchDecodePayload,
    input  pipelineControl_t            pipelineControl,
    input  logic [`XLEN-1:0]            readData1,
    input  logic [`XLEN-1:0]            readData2,
    output logic [`REG_ADDR_WIDTH-1:0]  readAddress1,
    output logic [`REG_ADDR_WIDTH-1:0]  readAddress2,
    output decodeExecutePayload_t       decodeExecutePayload
);

    immediateFormat_t immediateFormat;
    logic [`XLEN-1:0] immediate;
    decodeExecutePayload_t decodeCandidate;

    instructionDecoder instructionDecoder_i (
        .fetchDecodePayload (fetchDecodePayload),
        .readData1          (readData1),
        .readData2          (readData2),
        .immediate          (immediate),
        .immediateFormat    (immediateFormat),
        .readAddress1       (readAddress1), // Register file read, same cycle
        .readAddress2       (readAddress2),
        .decodeCandidate    (decodeCandidate)
    );

    immediateGenerator immediateGenerator_i (
        .instruction     (fetchDecodePayload.instruction),
        .immediateFormat (immediateFormat),
        .immediate       (immediate)
    );

    stageRegister stageRegister_i (
        .clock                (clock),
        .reset                (reset),
        .pipelineControl      (pipelineControl),
        .decodeCandidate      (decodeCandidate),
        .decodeExecutePayload (decodeExecutePayload)
    );

endmodule

//--- logic/immediateGenerator.sv
`timescale 1ns/10ps
`include "decode_config.svh"

module immediateGenerator import decodePkg::*; (
    input  logic [`XLEN-1:0] instruction,
    input  immediateFormat_t immediateFormat,
    output logic [`XLEN-1:0] immediate
);

    logic signBit;

    assign signBit = instruction[31];

    always_comb begin
        unique case (immediateFormat)
            IMM_I: begin
                immediate = {{(`XLEN-12){signBit}}, instruction[31:20]};
            end
            IMM_S: begin
                immediate = {{(`XLEN-12){signBit}}, instruction[31:25], instruction[11:7]};
            end
            IMM_B: begin // Halfword aligned offset
                immediate = {{(`XLEN-13){signBit}}, signBit, instruction[7],
                             instruction[30:25], instruction[11:8], 1'b0};
            end
            IMM_U: begin
                immediate = {instruction[31:12], 12'd0};
            end
            IMM_J: begin
                immediate = {{(`XLEN-21){signBit}}, signBit, instruction[19:12],
                             instruction[20], instruction[30:21], 1'b0};
            end
            default: immediate = '0; // IMM_NONE
        endcase
    end

endmodule

//--- logic/instructionDecoder.sv
`timescale 1ns/10ps
`include "decode_config.svh"

module instructionDecoder import decodePkg::*; (
    input  fetchDecodePayload_t              fetchDecodePayload,
    input  logic [`XLEN-1:0]                 readData1,
    input  logic [`XLEN-1:0]                 readData2,
    input  logic [`XLEN-1:0]                 immediate,
    output immediateFormat_t                 immediateFormat,
    output logic [`REG_ADDR_WIDTH-1:0]       readAddress1,
    output logic [`REG_ADDR_WIDTH-1:0]       readAddress2,
    output decodeExecutePayload_t            decodeCandidate
);

    logic [`XLEN-1:0] instruction;
    opcode_t opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic [`REG_ADDR_WIDTH-1:0] destinationField;
    logic [`REG_ADDR_WIDTH-1:0] source1Field;
    logic [`REG_ADDR_WIDTH-1:0] source2Field;
    logic zeroInstruction;
    decodeExecutePayload_t decoded;

    assign instruction = fetchDecodePayload.instruction;
    assign opcode = opcode_t'(instruction[6:0]);
    assign funct3 = instruction[14:12];
    assign funct7 = instruction[31:25];
    assign destinationField = instruction[11:7];
    assign source1Field = instruction[19:15];
    assign source2Field = instruction[24:20];
    assign zeroInstruction = (instruction == '0);

    always_comb begin
        decoded = '0;
        immediateFormat = IMM_NONE;
        readAddress1 = '0; // Unused sources stay at x0
        readAddress2 = '0;
        unique case (opcode)
            OPCODE_ALU_REG: begin
                readAddress1 = source1Field;
                readAddress2 = source2Field;
                decoded.destinationRegister = destinationField;
                decoded.aluSource = ALU_RS1_RS2;
                decoded.writebackType = WB_ALU;
                if (funct7 == `FUNCT7_BASE) begin
                    unique case (funct3)
                        3'b000: decoded.aluOperation = ALU_ADD;
                        3'b001: decoded.aluOperation = ALU_SLL;
                        3'b010: decoded.aluOperation = ALU_SLT;
                        3'b011: decoded.aluOperation = ALU_SLTU;
                        3'b100: decoded.aluOperation = ALU_XOR;
                        3'b101: decoded.aluOperation = ALU_SRL;
                        3'b110: decoded.aluOperation = ALU_OR;
                        3'b111: decoded.aluOperation = ALU_AND;
                    endcase
                end else if (funct7 == `FUNCT7_ALT && funct3 == 3'b000) begin
                    decoded.aluOperation = ALU_SUB;
                end else if (funct7 == `FUNCT7_ALT && funct3 == 3'b101) begin
                    decoded.aluOperation = ALU_SRA;
                end else begin
                    decoded.illegal = 1'b1;
                end
            end
            OPCODE_ALU_IMM: begin
                readAddress1 = source1Field;
                decoded.destinationRegister = destinationField;
                decoded.aluSource = ALU_RS1_IMM;
                decoded.writebackType = WB_ALU;
                immediateFormat = IMM_I;
                unique case (funct3)
                    3'b000: decoded.aluOperation = ALU_ADD;
                    3'b010: decoded.aluOperation = ALU_SLT;
                    3'b011: decoded.aluOperation = ALU_SLTU;
                    3'b100: decoded.aluOperation = ALU_XOR;
                    3'b110: decoded.aluOperation = ALU_OR;
                    3'b111: decoded.aluOperation = ALU_AND;
                    3'b001: begin // SLLI
                        if (funct7 == `FUNCT7_BASE) begin
                            decoded.aluOperation = ALU_SLL;
                        end else begin
                            decoded.illegal = 1'b1;
                        end
                    end
                    3'b101: begin
                        if (funct7 == `FUNCT7_BASE) begin
                            decoded.aluOperation = ALU_SRL;
                        end else if (funct7 == `FUNCT7_ALT) begin
                            decoded.aluOperation = ALU_SRA;
                        end else begin
                            decoded.illegal = 1'b1;
                        end
                    end
                endcase
            end
            OPCODE_LOAD: begin
                readAddress1 = source1Field;
                decoded.destinationRegister = destinationField;
                decoded.aluSource = ALU_RS1_IMM; // Address is rs1 plus offset
                decoded.writebackType = WB_MEM;
                decoded.memoryReadEnable = 1'b1;
                immediateFormat = IMM_I;
                unique case (funct3)
                    3'b000: {decoded.memoryWidth, decoded.memorySigned} = {MEM_BYTE, 1'b1};
                    3'b001: {decoded.memoryWidth, decoded.memorySigned} = {MEM_HALF, 1'b1};
                    3'b010: {decoded.memoryWidth, decoded.memorySigned} = {MEM_WORD, 1'b1};
                    3'b100: {decoded.memoryWidth, decoded.memorySigned} = {MEM_BYTE, 1'b0};
                    3'b101: {decoded.memoryWidth, decoded.memorySigned} = {MEM_HALF, 1'b0};
                    default: decoded.illegal = 1'b1;
                endcase
            end
            OPCODE_STORE: begin
                readAddress1 = source1Field;
                readAddress2 = source2Field; // Store data
                decoded.aluSource = ALU_RS1_IMM;
                decoded.memoryWriteEnable = 1'b1;
                immediateFormat = IMM_S;
                unique case (funct3)
                    3'b000: decoded.memoryWidth = MEM_BYTE;
                    3'b001: decoded.memoryWidth = MEM_HALF;
                    3'b010: decoded.memoryWidth = MEM_WORD;
                    default: decoded.illegal = 1'b1;
                endcase
            end
            OPCODE_BRANCH: begin
                readAddress1 = source1Field;
                readAddress2 = source2Field;
                decoded.aluSource = ALU_PC_IMM; // Target address
                immediateFormat = IMM_B;
                unique case (funct3)
                    3'b000: decoded.branchType = BR_EQ;
                    3'b001: decoded.branchType = BR_NE;
                    3'b100: decoded.branchType = BR_LT;
                    3'b101: decoded.branchType = BR_GE;
                    3'b110: decoded.branchType = BR_LTU;
                    3'b111: decoded.branchType = BR_GEU;
                    default: decoded.illegal = 1'b1;
                endcase
            end
            OPCODE_LUI: begin
                decoded.destinationRegister = destinationField;
                decoded.aluSource = ALU_ZERO_IMM;
                decoded.writebackType = WB_ALU;
                immediateFormat = IMM_U;
            end
            OPCODE_AUIPC: begin
                decoded.destinationRegister = destinationField;
                decoded.aluSource = ALU_PC_IMM;
                decoded.writebackType = WB_ALU;
                immediateFormat = IMM_U;
            end
            OPCODE_JAL: begin
                decoded.destinationRegister = destinationField;
                decoded.aluSource = ALU_PC_IMM;
                decoded.writebackType = WB_PC4;
                decoded.jumpType = JUMP_JAL;
                immediateFormat = IMM_J;
            end
            OPCODE_JALR: begin
                readAddress1 = source1Field;
                decoded.destinationRegister = destinationField;
                decoded.aluSource = ALU_RS1_IMM;
                decoded.writebackType = WB_PC4;
                decoded.jumpType = JUMP_JALR;
                immediateFormat = IMM_I;
                decoded.illegal = (funct3 != 3'b000);
            end
            OPCODE_MISC_MEM: begin
                // In-order pipeline, FENCE needs no action
            end
            OPCODE_SYSTEM: begin
                readAddress1 = source1Field; // No-op like FENCE, fields kept
                decoded.destinationRegister = destinationField;
                decoded.writebackType = WB_NONE;
            end
            default: decoded.illegal = 1'b1;
        endcase
        decoded.immediate = immediate;
        decoded.readAddress1 = readAddress1;
        decoded.readAddress2 = readAddress2;
        decoded.registerData1 = readData1;
        decoded.registerData2 = readData2;
        decoded.programCounter = fetchDecodePayload.programCounter;
        decoded.programCounterPlus4 = fetchDecodePayload.programCounterPlus4;
        decoded.valid = fetchDecodePayload.valid;
    end

    // All-zero word is a bubble, not an illegal instruction
    assign decodeCandidate = zeroInstruction ? '0 : decoded;

endmodule

//--- logic/stageRegister.sv
`timescale 1ns/10ps

module stageRegister import decodePkg::*; (
    input  logic                  clock,
    input  logic                  reset,
    input  pipelineControl_t      pipelineControl,
    input  decodeExecutePayload_t decodeCandidate,
    output decodeExecutePayload_t decodeExecutePayload
);

    always_ff @(posedge clock) begin
        if (reset) begin
            decodeExecutePayload <= '0;
        end else if (pipelineControl.flush) begin
            decodeExecutePayload.valid <= 1'b0; // Kill only, fields hold
        end else if (!pipelineControl.stall) begin
            decodeExecutePayload <= decodeCandidate;
        end
    end

endmodule

//--- tb/clockReset.sv
`timescale 1ns/10ps

module clockReset #(
    parameter int PERIOD = 40,
    parameter int RESET_CYCLES = 8
) (
    output logic clock,
    output logic reset
);

    initial begin
        clock = 1'b0;
        forever #(PERIOD / 2) clock = ~clock;
    end

    initial begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clock);
        #1 reset = 1'b0; // Released just after the edge, like the other inputs
    end

endmodule

//--- tb/decodeStageTb.sv
`timescale 1ns/10ps
`include "decode_config.svh"

module decodeStageTb import decodePkg::*; ();

    localparam int CLOCK_PERIOD = 40;
    localparam int RESET_CYCLES = 8;
    localparam int TEST_CYCLES = 800;

    logic clock;
    logic reset;
    logic armed = 1'b0; // Set once the first edge has given the outputs a value
    logic [31:0] randomState;
    logic [31:0] wordA;
    logic [31:0] wordB;
    fetchDecodePayload_t fetchPayload;
    pipelineControl_t control;
    logic [`XLEN-1:0] readData1;
    logic [`XLEN-1:0] readData2;
    logic [`REG_ADDR_WIDTH-1:0] readAddress1;
    logic [`REG_ADDR_WIDTH-1:0] readAddress2;
    decodeExecutePayload_t actualPayload;
    decodeExecutePayload_t currentExpected;
    decodeExecutePayload_t modelPayload;

    function automatic logic [31:0] xorshift(input logic [31:0] state);
        logic [31:0] x;
        x = state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // Register file contents, distinct for every index, x0 reads zero
    function automatic logic [`XLEN-1:0] registerValue(input logic [`REG_ADDR_WIDTH-1:0] index);
        if (index == '0) begin
            return '0;
        end
        return {3'b101, index, 3'b010, index, 11'h3c5, index};
    endfunction

    function automatic aluOperation_t baseAluOperation(input logic [2:0] funct3);
        case (funct3)
            3'd0: return ALU_ADD;
            3'd1: return ALU_SLL;
            3'd2: return ALU_SLT;
            3'd3: return ALU_SLTU;
            3'd4: return ALU_XOR;
            3'd5: return ALU_SRL;
            3'd6: return ALU_OR;
            default: return ALU_AND;
        endcase
    endfunction

    function automatic decodeExecutePayload_t referenceDecode(input fetchDecodePayload_t fetch);
        decodeExecutePayload_t e;
        logic [31:0] ins;
        logic [2:0] f3;
        logic [6:0] f7;
        logic [31:0] immI;
        logic [31:0] immS;
        logic [31:0] immB;
        logic [31:0] immU;
        logic [31:0] immJ;
        ins = fetch.instruction;
        f3 = ins[14:12];
        f7 = ins[31:25];
        immI = {{20{ins[31]}}, ins[31:20]};
        immS = {{20{ins[31]}}, ins[31:25], ins[11:7]};
        immB = {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
        immU = {ins[31:12], 12'h000};
        immJ = {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
        e = '0;
        if (ins == '0) begin
            return e; // Bubble
        end
        case (ins[6:0])
            OPCODE_ALU_REG: begin
                e.readAddress1 = ins[19:15];
                e.readAddress2 = ins[24:20];
                e.destinationRegister = ins[11:7];
                e.aluSource = ALU_RS1_RS2;
                e.writebackType = WB_ALU;
                if (f7 == `FUNCT7_BASE) begin
                    e.aluOperation = baseAluOperation(f3);
                end else if (f7 == `FUNCT7_ALT && f3 == 3'd0) begin
                    e.aluOperation = ALU_SUB;
                end else if (f7 == `FUNCT7_ALT && f3 == 3'd5) begin
                    e.aluOperation = ALU_SRA;
                end else begin
                    e.illegal = 1'b1;
                end
            end
            OPCODE_ALU_IMM: begin
                e.readAddress1 = ins[19:15];
                e.destinationRegister = ins[11:7];
                e.aluSource = ALU_RS1_IMM;
                e.writebackType = WB_ALU;
                e.immediate = immI;
                if (f3 != 3'd1 && f3 != 3'd5) begin
                    e.aluOperation = baseAluOperation(f3);
                end else if (f7 == `FUNCT7_BASE) begin
                    e.aluOperation = baseAluOperation(f3);
                end else if (f7 == `FUNCT7_ALT && f3 == 3'd5) begin
                    e.aluOperation = ALU_SRA;
                end else begin
                    e.illegal = 1'b1; // Bad shift funct7
                end
            end
            OPCODE_LOAD: begin
                e.readAddress1 = ins[19:15];
                e.destinationRegister = ins[11:7];
                e.aluSource = ALU_RS1_IMM;
                e.writebackType = WB_MEM;
                e.memoryReadEnable = 1'b1;
                e.immediate = immI;
                if (f3[1:0] != 2'b11 && f3 != 3'b110) begin
                    e.memoryWidth = memoryWidth_t'({f3[1], f3[1] | f3[0]});
                    e.memorySigned = !f3[2];
                end else begin
                    e.illegal = 1'b1;
                end
            end
            OPCODE_STORE: begin
                e.readAddress1 = ins[19:15];
                e.readAddress2 = ins[24:20];
                e.aluSource = ALU_RS1_IMM;
                e.memoryWriteEnable = 1'b1;
                e.immediate = immS;
                if (f3 < 3'd3) begin
                    e.memoryWidth = memoryWidth_t'({f3[1], f3[1] | f3[0]});
                end else begin
                    e.illegal = 1'b1;
                end
            end
            OPCODE_BRANCH: begin
                e.readAddress1 = ins[19:15];
                e.readAddress2 = ins[24:20];
                e.aluSource = ALU_PC_IMM;
                e.immediate = immB;
                case (f3)
                    3'd0: e.branchType = BR_EQ;
                    3'd1: e.branchType = BR_NE;
                    3'd4: e.branchType = BR_LT;
                    3'd5: e.branchType = BR_GE;
                    3'd6: e.branchType = BR_LTU;
                    3'd7: e.branchType = BR_GEU;
                    default: e.illegal = 1'b1;
                endcase
            end
            OPCODE_LUI, OPCODE_AUIPC: begin
                e.destinationRegister = ins[11:7];
                e.writebackType = WB_ALU;
                e.immediate = immU;
                if (ins[5]) begin
                    e.aluSource = ALU_ZERO_IMM; // LUI
                end else begin
                    e.aluSource = ALU_PC_IMM;
                end
            end
            OPCODE_JAL: begin
                e.destinationRegister = ins[11:7];
                e.aluSource = ALU_PC_IMM;
                e.writebackType = WB_PC4;
                e.jumpType = JUMP_JAL;
                e.immediate = immJ;
            end
            OPCODE_JALR: begin
                e.readAddress1 = ins[19:15];
                e.destinationRegister = ins[11:7];
                e.aluSource = ALU_RS1_IMM;
                e.writebackType = WB_PC4;
                e.jumpType = JUMP_JALR;
                e.immediate = immI;
                e.illegal = (f3 != 3'd0);
            end
            OPCODE_MISC_MEM: begin
            end
            OPCODE_SYSTEM: begin
                e.readAddress1 = ins[19:15];
                e.destinationRegister = ins[11:7];
            end
            default: e.illegal = 1'b1;
        endcase
        e.registerData1 = registerValue(e.readAddress1);
        e.registerData2 = registerValue(e.readAddress2);
        e.programCounter = fetch.programCounter;
        e.programCounterPlus4 = fetch.programCounterPlus4;
        e.valid = fetch.valid;
        return e;
    endfunction

    function automatic logic [31:0] assembleInstruction(input logic [31:0] a, input logic [31:0] b);
        logic [6:0] opcode;
        logic [6:0] funct7;
        if (b[31:28] == 4'd0) begin
            return '0;
        end
        case (a[3:0])
            4'd0: opcode = OPCODE_ALU_REG;
            4'd1: opcode = OPCODE_ALU_IMM;
            4'd2: opcode = OPCODE_LOAD;
            4'd3: opcode = OPCODE_STORE;
            4'd4: opcode = OPCODE_BRANCH;
            4'd5: opcode = OPCODE_LUI;
            4'd6: opcode = OPCODE_AUIPC;
            4'd7: opcode = OPCODE_JAL;
            4'd8: opcode = OPCODE_JALR;
            4'd9: opcode = OPCODE_MISC_MEM;
            4'd10: opcode = OPCODE_SYSTEM;
            default: opcode = b[6:0]; // Mostly unknown opcodes
        endcase
        case (a[5:4])
            2'd2: funct7 = `FUNCT7_ALT;
            2'd3: funct7 = b[13:7];
            default: funct7 = `FUNCT7_BASE;
        endcase
        return {funct7, a[23:19], a[18:14], a[8:6], a[13:9], opcode};
    endfunction

    task automatic reportMismatch(input string signalName, input string expectedText,
                                  input string actualText);
        $display("mismatch at %0t ns: %s expected %s actual %s", $time, signalName,
                 expectedText, actualText);
        $display("Finished with errors");
        $fatal(1, "Stopped at the first error");
    endtask

    clockReset #(.PERIOD(CLOCK_PERIOD), .RESET_CYCLES(RESET_CYCLES)) clockReset_i (
        .clock (clock),
        .reset (reset)
    );

    decodeStage dut_i (
        .clock                (clock),
        .reset                (reset),
        .fetchDecodePayload   (fetchPayload),
        .pipelineControl      (control),
        .readData1            (readData1),
        .readData2            (readData2),
        .readAddress1         (readAddress1),
        .readAddress2         (readAddress2),
        .decodeExecutePayload (actualPayload)
    );

    assign readData1 = registerValue(readAddress1); // Register file answers in the same cycle
    assign readData2 = registerValue(readAddress2);

    always_comb begin
        currentExpected = referenceDecode(fetchPayload);
    end

    // Expected stage register
    always @(posedge clock) begin
        armed <= 1'b1;
        if (reset) begin
            modelPayload <= '0;
        end else if (control.flush) begin
            modelPayload.valid <= 1'b0;
        end else if (!control.stall) begin
            modelPayload <= currentExpected;
        end
    end

    payloadCheck: assert property (@(negedge clock) armed |-> (actualPayload == modelPayload))
        else reportMismatch("decodeExecutePayload", $sformatf("%h", modelPayload),
                            $sformatf("%h", actualPayload));

    resetCheck: assert property (@(negedge clock) (armed && reset) |-> (actualPayload == '0))
        else reportMismatch("decodeExecutePayload", "0", $sformatf("%h", actualPayload));

    address1Check: assert property (@(negedge clock)
                                    armed |-> (readAddress1 == currentExpected.readAddress1))
        else reportMismatch("readAddress1", $sformatf("%h", currentExpected.readAddress1),
                            $sformatf("%h", readAddress1));

    address2Check: assert property (@(negedge clock)
                                    armed |-> (readAddress2 == currentExpected.readAddress2))
        else reportMismatch("readAddress2", $sformatf("%h", currentExpected.readAddress2),
                            $sformatf("%h", readAddress2));

    initial begin
        randomState = 32'h3949_880a;
        fetchPayload.instruction = 32'h0042_8293; // ADDI x5, x5, 4 held through reset
        fetchPayload.programCounter = 32'h0000_1000;
        fetchPayload.programCounterPlus4 = 32'h0000_1004;
        fetchPayload.valid = 1'b1;
        control = '0;
        @(negedge reset);
        repeat (TEST_CYCLES) begin
            @(posedge clock);
            #1;
            randomState = xorshift(randomState);
            wordA = randomState;
            randomState = xorshift(randomState);
            wordB = randomState;
            randomState = xorshift(randomState);
            fetchPayload.instruction = assembleInstruction(wordA, wordB);
            fetchPayload.programCounter = {randomState[31:2], 2'b00};
            fetchPayload.programCounterPlus4 = {randomState[31:2], 2'b00} + 32'd4;
            fetchPayload.valid = (wordB[20:18] != 3'd0);
            control.stall = (wordB[26:24] == 3'd0); // About one cycle in eight
            control.flush = (wordB[23:21] == 3'd0);
        end
        repeat (2) @(posedge clock);
        #1;
        $display("Finished with no errors");
        $finish;
    end

    // Watchdog
    initial begin
        #((RESET_CYCLES + TEST_CYCLES + 20) * CLOCK_PERIOD);
        $display("Watchdog expired before the test reached its end");
        $display("Finished with errors");
        $fatal(1, "Timeout");
    end

endmodule
